//--- design/frame_buffer.sv
//============================================================
// Frame buffer
//  240x160 RGB555 words, single clock
//  One write port, one registered read port
//============================================================
`timescale 1ns/1ps
`include "gba_video_cfg.svh"

module frame_buffer (
	input  logic                    clk_sys,
	input  logic                    wr_en,
	input  gba_pixel_pkg::fb_addr_t wr_addr,
	input  gba_pixel_pkg::rgb555_t  wr_data,
	input  gba_pixel_pkg::fb_addr_t rd_addr,
	output gba_pixel_pkg::rgb555_t  rd_data   // Valid one cycle after rd_addr
);

	// One word per visible pixel, contents undefined until written
	gba_pixel_pkg::rgb555_t mem [`GBA_FRAME_PIXELS];

	//============================================================
	// Write port, core side
	//============================================================
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	//============================================================
	// Read port, scan side
	//============================================================
	// Read-before-write on a same-address collision
	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- design/frame_writer.sv
//============================================================
// Frame writer
//  Registers core pixel strobes towards the frame buffer
//  Stretched frame-end pulse on a write to the last pixel
//============================================================
`timescale 1ns/1ps
`include "gba_video_cfg.svh"

module frame_writer (
	input  logic                    clk_sys,
	input  logic                    arst_n,
	input  logic                    pixel_we,    // One cycle per pixel
	input  gba_pixel_pkg::fb_addr_t pixel_addr,
	input  gba_pixel_pkg::rgb555_t  pixel_data,
	output logic                    wr_en,
	output gba_pixel_pkg::fb_addr_t wr_addr,
	output gba_pixel_pkg::rgb555_t  wr_data,
	output logic                    frame_end    // GBA_FRAME_END_LEN cycles high
);

	logic                          last_hit;     // Strobe at the last pixel
	logic [`GBA_FRAME_END_LEN-1:0] end_sr;       // Stretch register

	// Core finishes a frame by writing pixel 38399
	assign last_hit = pixel_we &&
		(pixel_addr == gba_pixel_pkg::fb_addr_t'(`GBA_FRAME_PIXELS - 1));

	//============================================================
	// Control path
	//============================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_en     <= 1'b0;
			end_sr    <= '0;
			frame_end <= 1'b0;
		end else begin
			wr_en     <= pixel_we;                                      // Write strobe, one stage
			end_sr    <= {end_sr[`GBA_FRAME_END_LEN-2:0], last_hit};  // Shift the hit along
			frame_end <= |end_sr;                                       // High while any bit set
		end
	end

	// Address and colour only move with a strobe
	always_ff @(posedge clk_sys) begin
		if (pixel_we) begin
			wr_addr <= pixel_addr;
			wr_data <= pixel_data;
		end
	end

	// Core never writes past the visible frame
	a_addr_range: assert property (@(posedge clk_sys) disable iff (!arst_n)
		pixel_we |-> (pixel_addr < `GBA_FRAME_PIXELS))
		else $error("pixel write outside frame, addr %0d", pixel_addr);

endmodule

//--- design/gba_pixel_pkg.sv
//============================================================
// Pixel types
//  RGB555 core colour, RGB888 LCD colour
//  Frame buffer address
//============================================================
`include "gba_video_cfg.svh"

package gba_pixel_pkg;

	// Core colour, red in the top bits
	typedef struct packed {
		logic [`GBA_CHAN_W-1:0] r;
		logic [`GBA_CHAN_W-1:0] g;
		logic [`GBA_CHAN_W-1:0] b;
	} rgb555_t;

	// Widened colour driven to the panel
	typedef struct packed {
		logic [`GBA_OUT_CHAN_W-1:0] r;
		logic [`GBA_OUT_CHAN_W-1:0] g;
		logic [`GBA_OUT_CHAN_W-1:0] b;
	} rgb888_t;

	// Linear address, line * 240 + pixel
	typedef logic [`GBA_ADDR_W-1:0] fb_addr_t;

endpackage

//--- design/gba_timing_pkg.sv
//============================================================
// Scan timing types
//  Position and line counters
//  Pixel enable divider count
//============================================================
`include "gba_video_cfg.svh"

package gba_timing_pkg;

	// Position within a line, or line within a frame
	// Both run 0..255, wrap is natural
	typedef logic [`GBA_POS_W-1:0] scan_pos_t;

	// Counts clk_sys cycles between pixel enables
	typedef logic [`GBA_DIV_W-1:0] pix_div_t;

endpackage

//--- design/gba_video.sv
//============================================================
// Video path top
//  Frame writer, frame buffer, LCD scan generator
//============================================================
`timescale 1ns/1ps

module gba_video (
	input  logic                    clk_sys,
	input  logic                    arst_n,
	// Core pixel strobes
	input  logic                    pixel_we,
	input  gba_pixel_pkg::fb_addr_t pixel_addr,
	input  gba_pixel_pkg::rgb555_t  pixel_data,
	// LCD side
	output logic                    pix_ce,
	output logic                    hs,
	output logic                    vs,
	output logic                    hbl,
	output logic                    vbl,
	output logic                    de,
	output gba_pixel_pkg::rgb888_t  rgb
);

	// Writer to buffer
	logic                    wr_en;
	gba_pixel_pkg::fb_addr_t wr_addr;
	gba_pixel_pkg::rgb555_t  wr_data;
	// Writer to scan
	logic                    frame_end;
	// Scan to buffer and back
	gba_pixel_pkg::fb_addr_t rd_addr;
	gba_pixel_pkg::rgb555_t  rd_data;

	frame_writer frame_writer_inst (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.pixel_we   (pixel_we),
		.pixel_addr (pixel_addr),
		.pixel_data (pixel_data),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.frame_end  (frame_end)
	);

	frame_buffer frame_buffer_inst (
		.clk_sys (clk_sys),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	lcd_scan lcd_scan_inst (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.frame_end (frame_end),
		.rd_data   (rd_data),
		.rd_addr   (rd_addr),
		.pix_ce    (pix_ce),
		.hs        (hs),
		.vs        (vs),
		.hbl       (hbl),
		.vbl       (vbl),
		.de        (de),
		.rgb       (rgb)
	);

endmodule

//--- design/gba_video_cfg.svh
//============================================================
// Video path constants
//  Frame geometry and buffer size
//  Scan positions for sync and blanking
//  Pixel enable divide, frame-end pulse length, field widths
//============================================================
`ifndef GBA_VIDEO_CFG_SVH
`define GBA_VIDEO_CFG_SVH

//============================================================
// Frame geometry
//============================================================
`define GBA_FRAME_W        240    // Active pixels per line
`define GBA_FRAME_H        160    // Active lines
`define GBA_FRAME_PIXELS   38400  // W * H, also the buffer depth

//============================================================
// Scan timing, in pixel positions and lines
//============================================================
`define GBA_PIX_DIV        4      // clk_sys cycles per pixel enable
`define GBA_HS_START       244    // First position with hsync
`define GBA_HS_END         252    // First position after hsync
`define GBA_VS_START       163    // Line where vsync starts
`define GBA_VS_END         166    // Line where vsync ends
`define GBA_VBL_START      160    // First blanked line

// Frame-end pulse, stretched so the scan side always sees it
`define GBA_FRAME_END_LEN  4

//============================================================
// Field widths
//============================================================
`define GBA_ADDR_W         16     // Buffer address
`define GBA_CHAN_W         5      // Core colour channel
`define GBA_OUT_CHAN_W     8      // LCD colour channel
`define GBA_POS_W          8      // 256 positions, 256 lines
`define GBA_DIV_W          2      // Holds 0 .. GBA_PIX_DIV-1

`endif

//--- design/lcd_scan.sv
//============================================================
// LCD scan generator
//  Pixel enable divider, position and line counters
//  Sync, blanking and data enable, frame arming
//  Buffer read addressing and RGB555 to RGB888 widening
//============================================================
`timescale 1ns/1ps
`include "gba_video_cfg.svh"

module lcd_scan (
	input  logic                    clk_sys,
	input  logic                    arst_n,
	input  logic                    frame_end,  // Stretched pulse from the writer
	input  gba_pixel_pkg::rgb555_t  rd_data,
	output gba_pixel_pkg::fb_addr_t rd_addr,
	output logic                    pix_ce,     // One cycle in GBA_PIX_DIV
	output logic                    hs,
	output logic                    vs,
	output logic                    hbl,
	output logic                    vbl,
	output logic                    de,
	output gba_pixel_pkg::rgb888_t  rgb
);

	gba_timing_pkg::pix_div_t  div;       // Enable divider
	gba_timing_pkg::scan_pos_t x;         // Position in line
	gba_timing_pkg::scan_pos_t y;         // Line in frame
	logic                      ce_next;   // pix_ce rises on this edge
	logic                      at_end;    // Last position of last line
	logic                      wrap;      // Armed frame restarts here
	logic                      fe_q;      // frame_end, one cycle late
	logic                      fe_rise;
	logic                      armed;     // Frame end seen since last wrap
	gba_pixel_pkg::rgb555_t    pix;       // Colour of the shown pixel

	assign ce_next = (div == gba_timing_pkg::pix_div_t'(`GBA_PIX_DIV - 1));
	assign at_end  = (&x) && (&y);
	assign wrap    = pix_ce && at_end && armed;
	assign fe_rise = frame_end && !fe_q;

	//============================================================
	// Pixel enable
	//============================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			div    <= '0;
			pix_ce <= 1'b0;
		end else begin
			div    <= ce_next ? '0 : div + 1'b1;
			pix_ce <= ce_next;   // 4th edge after reset is the first
		end
	end

	//============================================================
	// Sync, blanking, enable
	//============================================================
	// All decoded from the position about to be shown
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			hs  <= 1'b0;
			vs  <= 1'b0;
			hbl <= 1'b0;
			vbl <= 1'b0;
			de  <= 1'b0;
		end else if (ce_next) begin
			hbl <= (x >= `GBA_FRAME_W);       // Positions 240..255
			vbl <= (y >= `GBA_VBL_START);     // Lines 160..255
			de  <= (x < `GBA_FRAME_W) && (y < `GBA_FRAME_H);
			if (x == `GBA_HS_START) begin
				hs <= 1'b1;
				// vsync edges line up with hsync start
				if (y == `GBA_VS_START) vs <= 1'b1;
				if (y == `GBA_VS_END)   vs <= 1'b0;
			end
			if (x == `GBA_HS_END) hs <= 1'b0;
		end
	end

	// Buffer data for address k arrives before the k-th active enable
	always_ff @(posedge clk_sys) begin
		if (ce_next) pix <= rd_data;
	end

	//============================================================
	// Counters and read address
	//============================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			x       <= '0;
			y       <= '0;
			rd_addr <= '0;
		end else if (pix_ce) begin
			if (de) rd_addr <= rd_addr + 1'b1;   // Next active pixel
			if (at_end) begin
				// Hold on 255/255 until the core ends a frame
				if (armed) begin
					x       <= '0;
					y       <= '0;
					rd_addr <= '0;
				end
			end else begin
				x <= x + 1'b1;
				if (&x) y <= y + 1'b1;
			end
		end
	end

	// Frame arming from the writer pulse
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			fe_q  <= 1'b0;
			armed <= 1'b0;
		end else begin
			fe_q <= frame_end;
			if (wrap)    armed <= 1'b0;
			if (fe_rise) armed <= 1'b1;   // A new end beats the clear
		end
	end

	// Top three bits repeated into the low bits
	assign rgb.r = {pix.r, pix.r[`GBA_CHAN_W-1 -: 3]};
	assign rgb.g = {pix.g, pix.g[`GBA_CHAN_W-1 -: 3]};
	assign rgb.b = {pix.b, pix.b[`GBA_CHAN_W-1 -: 3]};

	//============================================================
	// Checks
	//============================================================
	// hsync only ever starts inside the horizontal blank
	a_hs_hbl: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$rose(hs) |-> hbl)
		else $error("hsync outside hblank on line %0d", y);

	// Reads stay within one frame between wraps
	a_rd_range: assert property (@(posedge clk_sys) disable iff (!arst_n)
		rd_addr <= `GBA_FRAME_PIXELS)
		else $error("read address %0d past frame", rd_addr);

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the video path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module gba_video_tb -o gba_video_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/gba_video_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Test passed" <<< "$out"; then
	exit 0
fi
exit 1

//--- src.f
+incdir+design
design/gba_pixel_pkg.sv
design/gba_timing_pkg.sv
design/frame_writer.sv
design/frame_buffer.sv
design/lcd_scan.sv
design/gba_video.sv
tests/gba_video_tb.sv

//--- tests/gba_video_tb.sv
//============================================================
// Video path testbench
//  Clock, reset, file-driven pixel writes, LFSR filler
//  Scan position model, timing and pixel checks
//  Frame hold check, watchdog, error summary
//============================================================
`timescale 1ns/1ps
`include "gba_video_cfg.svh"

module gba_video_tb;

	logic        clk_sys;
	logic        arst_n;
	logic        pixel_we;
	logic [15:0] pixel_addr;
	logic [14:0] pixel_data;
	logic        pix_ce, hs, vs, hbl, vbl, de;
	logic [23:0] rgb;

	logic [14:0] model [int];           // Expected buffer words by address
	logic [31:0] lfsr_state = 32'h3666;
	int          frames;                // Checked frames after the first wrap
	int          write_count;           // Strobes the stimulus will issue
	bit          loaded;
	int          timing_errs, pixel_errs, other_errs;
	int          pix_checked;
	// Scan model, advanced on each pix_ce
	int          pos, line, frame_no, gap;
	bit          seen_ce;
	logic [4:0]  last_out;              // hs, vs, hbl, vbl, de at the last enable
	logic        exp_hbl, exp_vbl, exp_hs, exp_vs, exp_de;
	int          k;

	gba_video gba_video_inst (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.pixel_we   (pixel_we),
		.pixel_addr (pixel_addr),
		.pixel_data (pixel_data),
		.pix_ce     (pix_ce),
		.hs         (hs),
		.vs         (vs),
		.hbl        (hbl),
		.vbl        (vbl),
		.de         (de),
		.rgb        (rgb)
	);

	initial clk_sys = 1'b0;
	always #2 clk_sys = ~clk_sys;   // 4 ns period

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] res;
		logic        fb;
		res = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			res        = {res[30:0], fb};
		end
		return res;
	endfunction

	// RGB555 to RGB888, top three bits of each channel repeated below
	function automatic logic [23:0] widen(input logic [14:0] c);
		logic [4:0] r, g, b;
		r = c[14:10];
		g = c[9:5];
		b = c[4:0];
		return {r, r[4:2], g, g[4:2], b, b[4:2]};
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			timing_errs++;
			$display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, got);
		end
	endtask

	// One strobe, inputs move 1 ns after the edge
	task automatic write_pixel(input logic [15:0] a, input logic [14:0] v);
		@(posedge clk_sys);
		#1;
		pixel_we   = 1'b1;
		pixel_addr = a;
		pixel_data = v;
		model[a]   = v;
		@(posedge clk_sys);
		#1;
		pixel_we   = 1'b0;
	endtask

	task automatic wait_frame(input int f);
		while (frame_no < f) @(posedge clk_sys);
	endtask

	//============================================================
	// Output monitor, sampled at the falling edge
	//============================================================
	always @(negedge clk_sys) begin
		if (!arst_n) begin
			seen_ce  = 0;
			gap      = 0;
			frame_no = 0;
			pos      = 0;
			line     = 0;
			last_out = '0;
		end else begin
			gap++;
			if (pix_ce) begin
				// Release lands just after an edge, so the first gap has one more sample
				check_val("pix_ce spacing",
					seen_ce ? `GBA_PIX_DIV : `GBA_PIX_DIV + 1, gap);
				if (seen_ce) begin
					if (pos == 255 && line == 255) begin
						// Wrap only shows as vbl dropping, else the scan holds
						if (!vbl) begin
							pos  = 0;
							line = 0;
							frame_no++;
						end
					end else begin
						if (pos == 255) line++;
						pos = (pos + 1) % 256;
					end
				end
				seen_ce = 1;
				gap     = 0;
				exp_hbl = (pos >= `GBA_FRAME_W);
				exp_vbl = (line >= `GBA_VBL_START);
				exp_hs  = (pos >= `GBA_HS_START) && (pos < `GBA_HS_END);
				exp_vs  = (line == `GBA_VS_START && pos >= `GBA_HS_START) ||
					(line > `GBA_VS_START && line < `GBA_VS_END) ||
					(line == `GBA_VS_END && pos < `GBA_HS_START);
				exp_de  = !(exp_hbl || exp_vbl);
				check_val("hbl", exp_hbl, hbl);
				check_val("vbl", exp_vbl, vbl);
				check_val("hs", exp_hs, hs);
				check_val("vs", exp_vs, vs);
				check_val("de", exp_de, de);
				last_out = {hs, vs, hbl, vbl, de};
				// Frame 0 shows an unwritten buffer
				if (exp_de && frame_no >= 1) begin
					k = line * `GBA_FRAME_W + pos;
					if (model.exists(k)) begin
						pix_checked++;
						assert (rgb === widen(model[k])) else begin
							pixel_errs++;
							$display("FAILED t=%0t rgb[%0d] expected %06h got %06h",
								$time, k, widen(model[k]), rgb);
						end
					end
				end
			end else begin
				// Nothing moves between enables, all low before the first one
				check_val("hs/vs/hbl/vbl/de", last_out, {hs, vs, hbl, vbl, de});
			end
		end
	end

	//============================================================
	// Watchdog
	//============================================================
	// Frame 0, checked frames, two-frame hold window, refill frame, writes
	initial begin
		longint limit;
		wait (loaded);
		limit = longint'(frames + 4) * 65536 * `GBA_PIX_DIV + 2 * write_count + 1000;
		repeat (limit) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, scan never reached its end", limit);
		$display("Test failed");
		$finish;
	end

	//============================================================
	// Stimulus
	//============================================================
	initial begin
		int          fd, n, f, held;
		string       txt;
		logic [7:0]  kind;
		logic [31:0] a, v;
		logic [15:0] fa [$];
		logic [14:0] fv [$];
		logic [14:0] last_val;
		bit          have_last;
		arst_n     = 1'b0;
		pixel_we   = 1'b0;
		pixel_addr = '0;
		pixel_data = '0;
		frames     = 1;
		have_last  = 0;
		last_val   = '0;
		fd = $fopen("tests/gba_video_tests.txt", "r");
		if (fd == 0) begin
			$display("Cannot open tests/gba_video_tests.txt");
			$display("Test failed");
			$finish;
		end else begin
			while ($fgets(txt, fd)) begin
				n = $sscanf(txt, "%c %h %h", kind, a, v);
				if (n >= 2 && kind == "F") frames = a;
				if (n == 3 && kind == "W") begin
					// Last-address write is held back, it arms the frame
					if (a == `GBA_FRAME_PIXELS - 1) begin
						last_val  = v[14:0];
						have_last = 1;
					end else begin
						fa.push_back(a[15:0]);
						fv.push_back(v[14:0]);
					end
				end
			end
			$fclose(fd);
			if (!have_last) begin
				other_errs++;
				$display("Test file has no write to the last pixel address");
			end
			// File words, filler, one arming write per frame plus the final one
			write_count = fa.size() + 64 + frames + 1;
			loaded = 1;
			repeat (5) @(posedge clk_sys);
			#1;
			arst_n = 1'b1;
			foreach (fa[i]) write_pixel(fa[i], fv[i]);
			for (int i = 0; i < 64; i++) begin
				write_pixel(16'(20000 + i * 37), 15'(lfsr_bits(15)));   // Filler words
			end
			write_pixel(16'(`GBA_FRAME_PIXELS - 1), last_val);
			// Re-arm in every checked frame but the last
			for (f = 1; f <= frames; f++) begin
				wait_frame(f);
				if (f < frames) begin
					repeat (10) @(posedge clk_sys);
					write_pixel(16'(`GBA_FRAME_PIXELS - 1), last_val);
				end
			end
			while (!(frame_no == frames && line == 255 && pos == 255)) @(posedge clk_sys);
			held = frame_no;
			repeat (2 * 65536 * `GBA_PIX_DIV) @(posedge clk_sys);
			assert (frame_no == held) else begin
				other_errs++;
				$display("Scan left the end of frame %0d without a frame end", held);
			end
			write_pixel(16'(`GBA_FRAME_PIXELS - 1), last_val);
			wait_frame(held + 1);   // vbl must fall again
			repeat (20) @(posedge clk_sys);
			if (pix_checked == 0) begin
				other_errs++;
				$display("No pixel of a written address was ever shown");
			end
			$display("Errors: timing %0d, pixel %0d, other %0d (%0d pixels compared)",
				timing_errs, pixel_errs, other_errs, pix_checked);
			if (timing_errs + pixel_errs + other_errs == 0) begin
				$display("Test passed");
			end else begin
				$display("Test failed");
			end
			$finish;
		end
	end

endmodule

//--- tests/gba_video_tests.txt
# Frame buffer stimulus for the video path testbench
# F <n> : number of checked frames, W <addr> <rgb555> : pixel write, both hex
F 2
# Corners of the first line
W 0000 7fff
W 0001 001f
W 00ef 03e0
# Start and end of the second line
W 00f0 7c00
W 01df 5294
# Mid frame
W 4b00 1234
W 4b01 6b5a
W 4b02 0421
W 4b03 7bde
# Scattered words
W 0100 2d6b
W 0800 56b5
W 1000 0000
W 2000 7fff
W 3000 4210
W 5000 318c
W 6000 1ce7
W 7000 6318
W 8000 2108
W 9000 739c
# Last line, first and some later pixels
W 9510 3def
W 9511 7c1f
W 95a0 03ff
W 95fe 5555
# Last pixel, arms the next frame
W 95ff 2aaa
